// ==== Bender.yml ====
package:
  name: control_unit

sources:
  - src/controlPkg.sv
  - src/instrDecoder.sv
  - src/stateSequencer.sv
  - src/controlOutputs.sv
  - src/controlUnit.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/controlUnitTb.sv

// ==== all.f ====
+incdir+test
src/controlPkg.sv
src/instrDecoder.sv
src/stateSequencer.sv
src/controlOutputs.sv
src/controlUnit.sv
test/controlUnitTb.sv

// ==== src/controlOutputs.sv ====
module controlOutputs (
    input  controlPkg::ctrlState   state,
    input  logic                   lastCycle,
    input  controlPkg::opClass     opClassIn,
    input  controlPkg::excCause    cause,
    output logic                   pcWrite,
    output controlPkg::iorDSel     iorD,
    output logic                   memRead,
    output controlPkg::memToRegSel memToReg,
    output logic                   irWrite,
    output logic                   multOrDiv,
    output logic                   hiWrite,
    output logic                   loWrite,
    output controlPkg::excCause    exception,
    output logic                   aluOutWrite,
    output controlPkg::pcSourceSel pcSource,
    output controlPkg::aluOpCode   aluOp,
    output controlPkg::aluSrcBSel  aluSrcB,
    output controlPkg::aluSrcASel  aluSrcA,
    output logic                   regWrite,
    output logic                   epcWrite,
    output logic                   writeA,
    output logic                   writeB
);

    import controlPkg::*;

    always_comb begin
        // everything inactive unless a state says otherwise
        pcWrite     = 1'b0;
        iorD        = AddrFromPc;
        memRead     = 1'b0;
        memToReg    = RegFromAluOut;
        irWrite     = 1'b0;
        multOrDiv   = 1'b0;
        hiWrite     = 1'b0;
        loWrite     = 1'b0;
        exception   = ExcOpcode;
        aluOutWrite = 1'b0;
        pcSource    = PcFromAlu;
        aluOp       = AluPassA;
        aluSrcB     = SrcBRegB;
        aluSrcA     = SrcAPc;
        regWrite    = 1'b0;
        epcWrite    = 1'b0;
        writeA      = 1'b0;
        writeB      = 1'b0;
        case (state)
            StFetch: begin
                // PC + 4 computed throughout, latched at the end
                memRead = 1'b1;
                aluSrcA = SrcAPc;
                aluSrcB = SrcBFour;
                aluOp   = AluAdd;
                irWrite = lastCycle;
                pcWrite = lastCycle;
            end
            StDecode: begin
                writeA = 1'b1;
                writeB = 1'b1;
            end
            StAluExec: begin
                aluSrcA     = SrcARegA;
                aluSrcB     = SrcBRegB;
                aluOutWrite = 1'b1;
                case (opClassIn)
                    OpSub: aluOp = AluSub;
                    OpAnd: aluOp = AluAnd;
                    default: aluOp = AluAdd;
                endcase
            end
            StAluWrite: begin
                regWrite = 1'b1;
                memToReg = RegFromAluOut;
            end
            StMulDiv: begin
                multOrDiv = (opClassIn == OpDiv);
                hiWrite   = lastCycle;
                loWrite   = lastCycle;
            end
            StMfhi: begin
                regWrite = 1'b1;
                memToReg = RegFromHi;
            end
            StMflo: begin
                regWrite = 1'b1;
                memToReg = RegFromLo;
            end
            StJr: begin
                aluSrcA = SrcARegA;
                aluOp   = AluPassA;
                pcWrite = 1'b1;
            end
            StJump: begin
                pcWrite  = 1'b1;
                pcSource = PcFromTarget;
            end
            StExcept: begin
                // PC holds until the vector load, so EPC keeps PC - 4
                epcWrite  = 1'b1;
                aluSrcA   = SrcAPc;
                aluSrcB   = SrcBFour;
                aluOp     = AluSub;
                memRead   = 1'b1;
                iorD      = AddrFromExc;
                exception = cause;
                pcWrite   = lastCycle;
                pcSource  = PcFromExcVector;
            end
            default: begin
                pcWrite = 1'b0;
            end
        endcase
    end

endmodule

// ==== src/controlPkg.sv ====
package controlPkg;

    // one instruction word seen two ways
    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rTypeFields;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [25:0] target;
    } jTypeFields;

    typedef union packed {
        rTypeFields rType;
        jTypeFields jType;
    } instrWord;

    typedef enum logic [3:0] {
        OpAdd, OpSub, OpAnd, OpMult, OpDiv,
        OpMfhi, OpMflo, OpJr, OpJump, OpIllegal
    } opClass;

    typedef enum logic [3:0] {
        StReset, StFetch, StDecode, StAluExec, StAluWrite, StMulDiv,
        StMfhi, StMflo, StJr, StJump, StExcept
    } ctrlState;

    // also picks the exception vector byte
    typedef enum logic [1:0] {
        ExcOpcode   = 2'd0,
        ExcOverflow = 2'd1,
        ExcDivZero  = 2'd2
    } excCause;

    localparam logic [5:0] OpcodeRType = 6'd0;
    localparam logic [5:0] OpcodeJ     = 6'd2;

    localparam logic [5:0] FunctAdd  = 6'd32;
    localparam logic [5:0] FunctSub  = 6'd34;
    localparam logic [5:0] FunctAnd  = 6'd36;
    localparam logic [5:0] FunctMult = 6'd24;
    localparam logic [5:0] FunctDiv  = 6'd26;
    localparam logic [5:0] FunctMfhi = 6'd16;
    localparam logic [5:0] FunctMflo = 6'd18;
    localparam logic [5:0] FunctJr   = 6'd8;

    typedef enum logic [2:0] {
        AluPassA = 3'd0,
        AluAdd   = 3'd1,
        AluSub   = 3'd2,
        AluAnd   = 3'd3
    } aluOpCode;

    typedef enum logic [1:0] {
        PcFromAlu       = 2'd0,
        PcFromAluOut    = 2'd1,
        PcFromTarget    = 2'd2,
        PcFromExcVector = 2'd3
    } pcSourceSel;

    typedef enum logic [2:0] {
        RegFromAluOut = 3'd0,
        RegFromHi     = 3'd2,
        RegFromLo     = 3'd3
    } memToRegSel;
    typedef enum logic [1:0] {AddrFromPc = 2'd0, AddrFromExc = 2'd2} iorDSel;
    typedef enum logic [1:0] {SrcAPc = 2'd0, SrcARegA = 2'd1} aluSrcASel;
    typedef enum logic [2:0] {SrcBRegB = 3'd0, SrcBFour = 3'd1} aluSrcBSel;

endpackage

// ==== src/controlUnit.sv ====
module controlUnit #(
    parameter int MemWaitCycles = 1,
    parameter int MulDivCycles  = 4
) (
    input  logic                   clk,
    input  logic                   reset,
    input  controlPkg::instrWord   instr,
    input  logic                   overflow,
    input  logic                   div0,
    output logic                   pcWrite,
    output controlPkg::iorDSel     iorD,
    output logic                   memRead,
    output controlPkg::memToRegSel memToReg,
    output logic                   irWrite,
    output logic                   multOrDiv,
    output logic                   hiWrite,
    output logic                   loWrite,
    output controlPkg::excCause    exception,
    output logic                   aluOutWrite,
    output controlPkg::pcSourceSel pcSource,
    output controlPkg::aluOpCode   aluOp,
    output controlPkg::aluSrcBSel  aluSrcB,
    output controlPkg::aluSrcASel  aluSrcA,
    output logic                   regWrite,
    output logic                   epcWrite,
    output logic                   writeA,
    output logic                   writeB
);

    import controlPkg::*;

    opClass   opClassSig;
    ctrlState state;
    logic     lastCycle;
    excCause  cause;

    instrDecoder decoder0 (
        .instr      (instr),
        .opClassOut (opClassSig)
    );

    stateSequencer #(
        .MemWaitCycles (MemWaitCycles),
        .MulDivCycles  (MulDivCycles)
    ) sequencer0 (
        .clk       (clk),
        .reset     (reset),
        .opClassIn (opClassSig),
        .overflow  (overflow),
        .div0      (div0),
        .state     (state),
        .lastCycle (lastCycle),
        .cause     (cause)
    );

    controlOutputs outputs0 (
        .state       (state),
        .lastCycle   (lastCycle),
        .opClassIn   (opClassSig),
        .cause       (cause),
        .pcWrite     (pcWrite),
        .iorD        (iorD),
        .memRead     (memRead),
        .memToReg    (memToReg),
        .irWrite     (irWrite),
        .multOrDiv   (multOrDiv),
        .hiWrite     (hiWrite),
        .loWrite     (loWrite),
        .exception   (exception),
        .aluOutWrite (aluOutWrite),
        .pcSource    (pcSource),
        .aluOp       (aluOp),
        .aluSrcB     (aluSrcB),
        .aluSrcA     (aluSrcA),
        .regWrite    (regWrite),
        .epcWrite    (epcWrite),
        .writeA      (writeA),
        .writeB      (writeB)
    );

endmodule

// ==== src/instrDecoder.sv ====
module instrDecoder (
    input  controlPkg::instrWord instr,
    output controlPkg::opClass   opClassOut
);

    import controlPkg::*;

    always_comb begin
        opClassOut = OpIllegal;
        case (instr.jType.opcode)
            OpcodeRType: begin
                // R-type operation sits in funct
                case (instr.rType.funct)
                    FunctAdd: begin
                        opClassOut = OpAdd;
                    end
                    FunctSub: begin
                        opClassOut = OpSub;
                    end
                    FunctAnd: begin
                        opClassOut = OpAnd;
                    end
                    FunctMult: begin
                        opClassOut = OpMult;
                    end
                    FunctDiv: begin
                        opClassOut = OpDiv;
                    end
                    FunctMfhi: begin
                        opClassOut = OpMfhi;
                    end
                    FunctMflo: begin
                        opClassOut = OpMflo;
                    end
                    FunctJr: begin
                        opClassOut = OpJr;
                    end
                    default: begin
                        opClassOut = OpIllegal;
                    end
                endcase
            end
            OpcodeJ: begin
                // target is consumed by the datapath
                opClassOut = OpJump;
            end
            default: begin
                opClassOut = OpIllegal;
            end
        endcase
    end

endmodule

// ==== src/stateSequencer.sv ====
module stateSequencer #(
    parameter int MemWaitCycles = 1,
    parameter int MulDivCycles  = 4
) (
    input  logic                 clk,
    input  logic                 reset,
    input  controlPkg::opClass   opClassIn,
    input  logic                 overflow,
    input  logic                 div0,
    output controlPkg::ctrlState state,
    output logic                 lastCycle,
    output controlPkg::excCause  cause
);

    import controlPkg::*;

    // counter must reach the longest phase end
    localparam int MaxLast = (MemWaitCycles + 1 > MulDivCycles - 1) ?
                             MemWaitCycles + 1 : MulDivCycles - 1;
    localparam int CntWidth = (MaxLast > 0) ? $clog2(MaxLast + 1) : 1;

    localparam logic [CntWidth-1:0] FetchLast  = CntWidth'(MemWaitCycles);
    localparam logic [CntWidth-1:0] ExceptLast = CntWidth'(MemWaitCycles + 1);
    localparam logic [CntWidth-1:0] MulDivLast = CntWidth'(MulDivCycles - 1);

    ctrlState            nextState;
    excCause             nextCause;
    logic [CntWidth-1:0] cycleCount;

    always_comb begin
        nextState = state;
        nextCause = cause;
        lastCycle = 1'b0;
        case (state)
            StReset: begin
                nextState = StFetch;
            end
            StFetch: begin
                lastCycle = (cycleCount == FetchLast);
                if (lastCycle) begin
                    nextState = StDecode;
                end
            end
            StDecode: begin
                case (opClassIn)
                    OpAdd, OpSub, OpAnd: begin
                        nextState = StAluExec;
                    end
                    OpMult, OpDiv: begin
                        nextState = StMulDiv;
                    end
                    OpMfhi: begin
                        nextState = StMfhi;
                    end
                    OpMflo: begin
                        nextState = StMflo;
                    end
                    OpJr: begin
                        nextState = StJr;
                    end
                    OpJump: begin
                        nextState = StJump;
                    end
                    default: begin
                        nextState = StExcept;
                        nextCause = ExcOpcode;
                    end
                endcase
            end
            StAluExec: begin
                // and never overflows
                if (overflow && (opClassIn == OpAdd || opClassIn == OpSub)) begin
                    nextState = StExcept;
                    nextCause = ExcOverflow;
                end else begin
                    nextState = StAluWrite;
                end
            end
            StMulDiv: begin
                lastCycle = (cycleCount == MulDivLast);
                // divisor checked once, in the first cycle
                if (cycleCount == '0 && opClassIn == OpDiv && div0) begin
                    nextState = StExcept;
                    nextCause = ExcDivZero;
                end else if (lastCycle) begin
                    nextState = StFetch;
                end
            end
            StExcept: begin
                lastCycle = (cycleCount == ExceptLast);
                if (lastCycle) begin
                    nextState = StFetch;
                    nextCause = ExcOpcode;
                end
            end
            StAluWrite, StMfhi, StMflo, StJr, StJump: begin
                nextState = StFetch;
            end
            default: begin
                nextState = StFetch;
            end
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= StReset;
            cause <= ExcOpcode;
        end else begin
            state <= nextState;
            cause <= nextCause;
        end
    end

    // restarts on every state change
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cycleCount <= '0;
        end else if (nextState != state) begin
            cycleCount <= '0;
        end else begin
            cycleCount <= cycleCount + 1'b1;
        end
    end

endmodule

// ==== test/controlUnitTests.svh ====
`ifndef CONTROL_UNIT_TESTS_SVH
`define CONTROL_UNIT_TESTS_SVH

task automatic startTest(input string name);
    testName = name;
    testErrors = 0;
endtask

task automatic compare(input string what, input int expected, input int actual);
    if (expected != actual) begin
        $display("Fail %s, %s: expected %0h, actual %0h", testName, what, expected, actual);
        testErrors++;
        failedChecks++;
    end
endtask

task automatic finishTest();
    testCount++;
    if (testErrors == 0) begin
        $display("%s: passed", testName);
    end else begin
        failedTests++;
        $display("%s: %0d checks failed", testName, testErrors);
    end
endtask

function automatic instrWord randomRWord(input logic [5:0] funct);
    instrWord w;
    w = instrWord'($random(seed));
    w.rType.opcode = OpcodeRType;
    w.rType.shamt = '0;
    w.rType.funct = funct;
    return w;
endfunction

function automatic instrWord randomWord(input logic [5:0] opcode);
    instrWord w;
    w = instrWord'($random(seed));
    w.jType.opcode = opcode;
    return w;
endfunction

// one cycle on, then the write enables of the new state
task automatic nextCycle(input string where, input int expWrites);
    @(negedge clk);
    compare({where, " writes"}, expWrites, writes);
endtask

task automatic fetchAndDecode(input instrWord word);
    for (int i = 0; i <= MemWaitCycles; i++) begin
        // IR and PC load in the last fetch cycle
        nextCycle("fetch", (i == MemWaitCycles) ? BitMem | BitIr | BitPc : BitMem);
        compare("fetch iorD", AddrFromPc, iorD);
        compare("fetch aluSrcA", SrcAPc, aluSrcA);
        compare("fetch aluSrcB", SrcBFour, aluSrcB);
        compare("fetch aluOp", AluAdd, aluOp);
        compare("fetch pcSource", PcFromAlu, pcSource);
    end
    instr = word;
    nextCycle("decode", BitA | BitB);
endtask

task automatic exceptionPhase(input excCause expCause);
    for (int i = 0; i < ExceptLen; i++) begin
        @(negedge clk);
        compare("exception writes", (i == ExceptLen - 1) ? BitMem | BitPc : BitMem,
                writes & ~BitEpc);
        if (i == 0) begin
            // PC - 4 goes to EPC
            compare("epcWrite", 1, epcWrite);
            compare("exception aluSrcA", SrcAPc, aluSrcA);
            compare("exception aluSrcB", SrcBFour, aluSrcB);
            compare("exception aluOp", AluSub, aluOp);
        end
        compare("exception iorD", AddrFromExc, iorD);
        compare("exception cause", expCause, exception);
        if (i == ExceptLen - 1) begin
            compare("exception pcSource", PcFromExcVector, pcSource);
        end
        overflow = 1'b0;
        div0 = 1'b0;
    end
endtask

task automatic resetAndFetch();
    startTest("resetFetch");
    repeat (4) begin
        @(negedge clk);
        compare("reset writes", 0, writes);
        compare("reset selects", 0,
                {iorD, memToReg, multOrDiv, exception, pcSource, aluOp, aluSrcB, aluSrcA});
    end
    reset = 1'b0;
    fetchAndDecode(randomWord(OpcodeJ));
    nextCycle("jump", BitPc);
    finishTest();
endtask

task automatic aluOperations();
    logic [5:0] functs[3];
    aluOpCode   ops[3];
    functs = '{FunctAdd, FunctSub, FunctAnd};
    ops = '{AluAdd, AluSub, AluAnd};
    startTest("aluOps");
    for (int k = 0; k < 3; k++) begin
        fetchAndDecode(randomRWord(functs[k]));
        nextCycle("execute", BitAluOut);
        compare("aluOp", ops[k], aluOp);
        compare("aluSrcA", SrcARegA, aluSrcA);
        compare("aluSrcB", SrcBRegB, aluSrcB);
        // overflow raised on and is ignored
        overflow = (functs[k] == FunctAnd);
        nextCycle("write-back", BitReg);
        compare("memToReg", RegFromAluOut, memToReg);
        overflow = 1'b0;
    end
    finishTest();
endtask

task automatic exceptionPaths();
    startTest("exceptions");
    fetchAndDecode(randomRWord(FunctAdd));
    nextCycle("execute", BitAluOut);
    overflow = 1'b1;
    exceptionPhase(ExcOverflow);
    // opcode 35 is a load, not implemented here
    fetchAndDecode(randomWord(6'd35));
    exceptionPhase(ExcOpcode);
    finishTest();
endtask

task automatic mulDivSequence();
    startTest("mulDiv");
    for (int k = 0; k < 2; k++) begin
        fetchAndDecode(randomRWord((k == 0) ? FunctMult : FunctDiv));
        for (int i = 0; i < MulDivCycles; i++) begin
            nextCycle("mulDiv", (i == MulDivCycles - 1) ? BitHi | BitLo : 0);
            compare("multOrDiv", k, multOrDiv);
        end
    end
    // zero divisor traps before any HI/LO write
    fetchAndDecode(randomRWord(FunctDiv));
    nextCycle("div", 0);
    compare("multOrDiv", 1, multOrDiv);
    div0 = 1'b1;
    exceptionPhase(ExcDivZero);
    finishTest();
endtask

task automatic movesAndJumps();
    startTest("moveJump");
    fetchAndDecode(randomRWord(FunctMfhi));
    nextCycle("mfhi", BitReg);
    compare("mfhi memToReg", RegFromHi, memToReg);
    fetchAndDecode(randomRWord(FunctMflo));
    nextCycle("mflo", BitReg);
    compare("mflo memToReg", RegFromLo, memToReg);
    fetchAndDecode(randomRWord(FunctJr));
    nextCycle("jr", BitPc);
    compare("jr pcSource", PcFromAlu, pcSource);
    compare("jr aluOp", AluPassA, aluOp);
    compare("jr aluSrcA", SrcARegA, aluSrcA);
    fetchAndDecode(randomWord(OpcodeJ));
    nextCycle("j", BitPc);
    compare("j pcSource", PcFromTarget, pcSource);
    // back in fetch
    nextCycle("fetch", (MemWaitCycles == 0) ? BitMem | BitIr | BitPc : BitMem);
    finishTest();
endtask

`endif

// ==== test/controlUnitTb.sv ====
module controlUnitTb;

    import controlPkg::*;

    localparam int MemWaitCycles = 1;
    localparam int MulDivCycles  = 4;
    // fetch plus decode and the exception phase lengths
    localparam int DecodeLen = MemWaitCycles + 2;
    localparam int ExceptLen = MemWaitCycles + 2;
    // all five tests back to back
    localparam int TestCycles = 4 + (DecodeLen + 1) + 3 * (DecodeLen + 2)
        + (2 * DecodeLen + 1 + 2 * ExceptLen)
        + (3 * DecodeLen + 2 * MulDivCycles + 1 + ExceptLen)
        + 4 * (DecodeLen + 1) + 1;
    localparam int TimeLimit = (TestCycles + 20) * 10;

    // write enable mask with memRead in bit 0
    localparam int BitPc     = 512;
    localparam int BitIr     = 256;
    localparam int BitHi     = 128;
    localparam int BitLo     = 64;
    localparam int BitAluOut = 32;
    localparam int BitReg    = 16;
    localparam int BitEpc    = 8;
    localparam int BitA      = 4;
    localparam int BitB      = 2;
    localparam int BitMem    = 1;

    logic       clk;
    logic       reset;
    logic       overflow;
    logic       div0;
    instrWord   instr;
    logic       pcWrite, memRead, irWrite, regWrite, epcWrite;
    logic       multOrDiv, hiWrite, loWrite, aluOutWrite, writeA, writeB;
    iorDSel     iorD;
    memToRegSel memToReg;
    excCause    exception;
    pcSourceSel pcSource;
    aluOpCode   aluOp;
    aluSrcBSel  aluSrcB;
    aluSrcASel  aluSrcA;
    logic [9:0] writes;

    integer seed;
    string  testName;
    int     testErrors = 0;
    int     testCount = 0;
    int     failedTests = 0;
    int     failedChecks = 0;

    assign writes = {pcWrite, irWrite, hiWrite, loWrite, aluOutWrite,
                     regWrite, epcWrite, writeA, writeB, memRead};

    controlUnit #(
        .MemWaitCycles (MemWaitCycles),
        .MulDivCycles  (MulDivCycles)
    ) dut0 (.*);

    `include "controlUnitTests.svh"

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    initial begin
        #(TimeLimit);
        $display("Watchdog expired after %0d time units before the tests completed", TimeLimit);
        $display("Something failed");
        $finish;
    end

    initial begin
        seed = 32'hab73cfb0;
        reset = 1'b1;
        instr = '0;
        overflow = 1'b0;
        div0 = 1'b0;
        resetAndFetch();
        aluOperations();
        exceptionPaths();
        mulDivSequence();
        movesAndJumps();
        $display("tests run %0d, tests failed %0d, checks failed %0d",
                 testCount, failedTests, failedChecks);
        if (failedChecks == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule
